/* verilog/lsu_pkg.sv */
//////////////////////////////
// Shared definitions of the uncached load/store path
// Access FSM states, AXI response codes, AXI size codes
//////////////////////////////

package lsu_pkg;

   // Uncached access FSM states
   typedef enum logic [1:0]
   {
      IDLE   = 2'd0,
      WAIT_B = 2'd1,
      WAIT_R = 2'd2,
      OUT    = 2'd3
   } unc_state_t;

   // AXI RRESP / BRESP encoding
   typedef enum logic [1:0]
   {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_t;

   // AXI ARSIZE / AWSIZE codes, bytes = 1 << size
   localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
   localparam logic [2:0] AXI_SIZE_DWORD = 3'd3;

endpackage

/* verilog/lsu_unc_fsm.sv */
//////////////////////////////
// Uncached access FSM, single-beat AXI master
// Address width adapter
// Write window replication, read window select
//////////////////////////////

`timescale 1ns/10ps

module lsu_unc_fsm
#(
   parameter config_aw      = 32,
   parameter config_dw      = 32,
   parameter axi_addr_width = 16,
   parameter axi_p_dw_bytes = 3
)
(
   input  logic                              clk,
   input  logic                              reset,
   // Pipeline side
   input  logic                              stall,
   input  logic                              boot,
   input  logic                              store,
   input  logic [config_aw-1:0]              paddr,
   input  logic [2:0]                        size,
   input  logic [config_dw-1:0]              wdat,
   input  logic [config_dw/8-1:0]            wmsk,
   output logic                              stall_req,
   output logic                              valid,
   output logic [config_dw-1:0]              dout,
   output logic                              err,
   // AXI read address and data
   input  logic                              ar_ready,
   output logic                              ar_valid,
   output logic [axi_addr_width-1:0]         ar_addr,
   output logic [2:0]                        ar_size,
   output logic                              r_ready,
   input  logic                              r_valid,
   input  logic [(1<<axi_p_dw_bytes)*8-1:0]  r_data,
   input  lsu_pkg::axi_resp_t                r_resp,
   // AXI write address, data and response
   input  logic                              aw_ready,
   output logic                              aw_valid,
   output logic [axi_addr_width-1:0]         aw_addr,
   output logic [2:0]                        aw_size,
   input  logic                              w_ready,
   output logic                              w_valid,
   output logic [(1<<axi_p_dw_bytes)*8-1:0]  w_data,
   output logic [(1<<axi_p_dw_bytes)-1:0]    w_strb,
   output logic                              b_ready,
   input  logic                              b_valid,
   input  lsu_pkg::axi_resp_t                b_resp
);
   import lsu_pkg::*;

   localparam axi_bytes = 1 << axi_p_dw_bytes;
   localparam win_bytes = config_dw / 8;
   localparam win_num   = axi_bytes / win_bytes;
   localparam win_p_dw  = $clog2(win_bytes);
   localparam win_mask  = win_num - 1;

   unc_state_t                   state;
   unc_state_t                   state_nxt;
   logic                         ar_set;
   logic                         aw_set;
   logic                         ar_hs;
   logic                         aw_hs;
   logic                         w_hs;
   logic                         r_hs;
   logic                         b_hs;
   logic [axi_addr_width-1:0]    addr_nxt;
   logic [axi_addr_width-1:0]    wr_sel;
   logic [axi_addr_width-1:0]    rd_sel;
   logic [axi_bytes*8-1:0]       wdata_nxt;
   logic [axi_bytes-1:0]         wstrb_nxt;
   logic [config_dw-1:0]         rd_win;

   always_comb
   begin
      state_nxt = state;
      ar_set = 1'b0;
      aw_set = 1'b0;
      case (state)
         IDLE:
            if (boot)
            begin
               state_nxt = store ? WAIT_B : WAIT_R;
               ar_set = ~store;
               aw_set = store;
            end
         WAIT_B:
            if (b_hs)
               state_nxt = OUT;
         WAIT_R:
            if (r_hs)
               state_nxt = OUT;
         OUT:
            // Hold the result while the pipeline stalls
            if (~stall)
               state_nxt = IDLE;
      endcase
   end

   assign ar_hs = ar_valid & ar_ready;
   assign aw_hs = aw_valid & aw_ready;
   assign w_hs  = w_valid & w_ready;
   assign r_hs  = r_valid & r_ready;
   assign b_hs  = b_valid & b_ready;

   assign r_ready = (state == WAIT_R);
   assign b_ready = (state == WAIT_B);

   // Request held from the boot cycle until the result is out
   assign stall_req = (state != OUT) & ((state != IDLE) | boot);
   assign valid = (state == OUT);

   // Physical address to AXI width, truncate or zero fill
   generate
      if (axi_addr_width > config_aw)
      begin : g_addr_fill
         assign addr_nxt = {{(axi_addr_width-config_aw){1'b0}}, paddr};
      end
      else
      begin : g_addr_trunc
         assign addr_nxt = paddr[axi_addr_width-1:0];
      end
   endgenerate

   // Window index within the bus word
   assign wr_sel = (addr_nxt >> win_p_dw) & axi_addr_width'(win_mask);
   assign rd_sel = (ar_addr >> win_p_dw) & axi_addr_width'(win_mask);

   // Same data in every window, mask only in the addressed one
   always_comb
   begin
      for (int i = 0; i < win_num; i++)
      begin
         wdata_nxt[i*config_dw +: config_dw] = wdat;
         wstrb_nxt[i*win_bytes +: win_bytes] = (wr_sel == axi_addr_width'(i)) ? wmsk : '0;
      end
   end

   always_comb
   begin
      rd_win = '0;
      for (int i = 0; i < win_num; i++)
         if (rd_sel == axi_addr_width'(i))
            rd_win = r_data[i*config_dw +: config_dw];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= IDLE;
         ar_valid <= 1'b0;
         aw_valid <= 1'b0;
         w_valid  <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (ar_set)
            ar_valid <= 1'b1;
         else if (ar_hs)
            ar_valid <= 1'b0;
         // AW and W rise together, drop on their own handshakes
         if (aw_set)
            aw_valid <= 1'b1;
         else if (aw_hs)
            aw_valid <= 1'b0;
         if (aw_set)
            w_valid <= 1'b1;
         else if (w_hs)
            w_valid <= 1'b0;
      end
   end

   // Channel payloads captured at boot
   always_ff @(posedge clk)
   begin
      if (ar_set)
      begin
         ar_addr <= addr_nxt;
         ar_size <= size;
      end
      if (aw_set)
      begin
         aw_addr <= addr_nxt;
         aw_size <= size;
         w_data  <= wdata_nxt;
         w_strb  <= wstrb_nxt;
      end
   end

   // Result word and error flag, dout is zero after a store
   always_ff @(posedge clk)
   begin
      if (r_hs)
      begin
         dout <= rd_win;
         err  <= (r_resp != OKAY);
      end
      else if (b_hs)
      begin
         dout <= '0;
         err  <= (b_resp != OKAY);
      end
   end

endmodule

/* verilog/axi_unc_ram.sv */
//////////////////////////////
// Single-beat AXI device RAM
// Byte strobes, AW/W in either order
// DECERR outside the depth
//////////////////////////////

`timescale 1ns/10ps

module axi_unc_ram
#(
   parameter axi_addr_width = 16,
   parameter axi_p_dw_bytes = 3,
   parameter ram_p_depth    = 9
)
(
   input  logic                              clk,
   input  logic                              reset,
   // Read address and data
   input  logic                              ar_valid,
   output logic                              ar_ready,
   input  logic [axi_addr_width-1:0]         ar_addr,
   input  logic [2:0]                        ar_size,
   output logic                              r_valid,
   input  logic                              r_ready,
   output logic [(1<<axi_p_dw_bytes)*8-1:0]  r_data,
   output lsu_pkg::axi_resp_t                r_resp,
   // Write address, data and response
   input  logic                              aw_valid,
   output logic                              aw_ready,
   input  logic [axi_addr_width-1:0]         aw_addr,
   input  logic [2:0]                        aw_size,
   input  logic                              w_valid,
   output logic                              w_ready,
   input  logic [(1<<axi_p_dw_bytes)*8-1:0]  w_data,
   input  logic [(1<<axi_p_dw_bytes)-1:0]    w_strb,
   output logic                              b_valid,
   input  logic                              b_ready,
   output lsu_pkg::axi_resp_t                b_resp
);
   import lsu_pkg::*;

   localparam bus_bytes = 1 << axi_p_dw_bytes;
   localparam depth     = 1 << ram_p_depth;
   localparam span_p    = axi_p_dw_bytes + ram_p_depth;

   logic [bus_bytes*8-1:0]       mem [depth];
   logic                         ar_hs;
   logic                         aw_hs;
   logic                         w_hs;
   logic                         aw_pend;
   logic                         w_pend;
   logic [axi_addr_width-1:0]    aw_addr_q;
   logic [2:0]                   aw_size_q;
   logic [bus_bytes*8-1:0]       w_data_q;
   logic [bus_bytes-1:0]         w_strb_q;
   logic                         wr_go;
   logic [axi_addr_width-1:0]    wr_addr;
   logic [2:0]                   wr_size;
   logic [bus_bytes*8-1:0]       wr_data;
   logic [bus_bytes-1:0]         wr_strb;
   logic                         wr_ok;
   logic                         rd_ok;
   logic [ram_p_depth-1:0]       wr_idx;
   logic [ram_p_depth-1:0]       rd_idx;

   // Ready whenever no response is held
   assign ar_ready = ~r_valid;
   assign aw_ready = ~aw_pend & ~b_valid;
   assign w_ready  = ~w_pend & ~b_valid;

   assign ar_hs = ar_valid & ar_ready;
   assign aw_hs = aw_valid & aw_ready;
   assign w_hs  = w_valid & w_ready;

   // Write once both halves are here, held or arriving now
   assign wr_go   = (aw_pend | aw_hs) & (w_pend | w_hs);
   assign wr_addr = aw_pend ? aw_addr_q : aw_addr;
   assign wr_size = aw_pend ? aw_size_q : aw_size;
   assign wr_data = w_pend ? w_data_q : w_data;
   assign wr_strb = w_pend ? w_strb_q : w_strb;

   // Decode, inside the depth and no wider than the bus
   assign wr_ok  = ((wr_addr >> span_p) == '0) && (wr_size <= AXI_SIZE_DWORD);
   assign rd_ok  = ((ar_addr >> span_p) == '0) && (ar_size <= AXI_SIZE_DWORD);
   assign wr_idx = ram_p_depth'(wr_addr >> axi_p_dw_bytes);
   assign rd_idx = ram_p_depth'(ar_addr >> axi_p_dw_bytes);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         aw_pend <= 1'b0;
         w_pend  <= 1'b0;
         r_valid <= 1'b0;
         b_valid <= 1'b0;
      end
      else
      begin
         if (wr_go)
            aw_pend <= 1'b0;
         else if (aw_hs)
            aw_pend <= 1'b1;
         if (wr_go)
            w_pend <= 1'b0;
         else if (w_hs)
            w_pend <= 1'b1;
         if (ar_hs)
            r_valid <= 1'b1;
         else if (r_ready)
            r_valid <= 1'b0;
         if (wr_go)
            b_valid <= 1'b1;
         else if (b_ready)
            b_valid <= 1'b0;
      end
   end

   // Held AW/W halves and response payloads
   always_ff @(posedge clk)
   begin
      if (aw_hs)
      begin
         aw_addr_q <= aw_addr;
         aw_size_q <= aw_size;
      end
      if (w_hs)
      begin
         w_data_q <= w_data;
         w_strb_q <= w_strb;
      end
      if (ar_hs)
      begin
         r_data <= rd_ok ? mem[rd_idx] : '0;
         r_resp <= rd_ok ? OKAY : DECERR;
      end
      if (wr_go)
         b_resp <= wr_ok ? OKAY : DECERR;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < depth; i++)
            mem[i] <= '0;
      end
      else if (wr_go && wr_ok)
      begin
         for (int b = 0; b < bus_bytes; b++)
            if (wr_strb[b])
               mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
   end

endmodule

/* verilog/lsu_unc_top.sv */
//////////////////////////////
// Uncached load/store path top level
// Access FSM wired to the AXI device RAM
//////////////////////////////

`timescale 1ns/10ps

module lsu_unc_top
#(
   parameter config_aw      = 32,
   parameter config_dw      = 32,
   parameter axi_addr_width = 16,
   parameter axi_p_dw_bytes = 3,
   parameter ram_p_depth    = 9
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    stall,
   input  logic                    boot,
   input  logic                    store,
   input  logic [config_aw-1:0]    paddr,
   input  logic [2:0]              size,
   input  logic [config_dw-1:0]    wdat,
   input  logic [config_dw/8-1:0]  wmsk,
   output logic                    stall_req,
   output logic                    valid,
   output logic [config_dw-1:0]    dout,
   output logic                    err
);
   import lsu_pkg::*;

   localparam axi_bytes = 1 << axi_p_dw_bytes;

   logic                         ar_valid;
   logic                         ar_ready;
   logic [axi_addr_width-1:0]    ar_addr;
   logic [2:0]                   ar_size;
   logic                         r_valid;
   logic                         r_ready;
   logic [axi_bytes*8-1:0]       r_data;
   axi_resp_t                    r_resp;
   logic                         aw_valid;
   logic                         aw_ready;
   logic [axi_addr_width-1:0]    aw_addr;
   logic [2:0]                   aw_size;
   logic                         w_valid;
   logic                         w_ready;
   logic [axi_bytes*8-1:0]       w_data;
   logic [axi_bytes-1:0]         w_strb;
   logic                         b_valid;
   logic                         b_ready;
   axi_resp_t                    b_resp;

   lsu_unc_fsm
   #(
      .config_aw      (config_aw),
      .config_dw      (config_dw),
      .axi_addr_width (axi_addr_width),
      .axi_p_dw_bytes (axi_p_dw_bytes)
   )
   u_fsm
   (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .boot      (boot),
      .store     (store),
      .paddr     (paddr),
      .size      (size),
      .wdat      (wdat),
      .wmsk      (wmsk),
      .stall_req (stall_req),
      .valid     (valid),
      .dout      (dout),
      .err       (err),
      .ar_ready  (ar_ready),
      .ar_valid  (ar_valid),
      .ar_addr   (ar_addr),
      .ar_size   (ar_size),
      .r_ready   (r_ready),
      .r_valid   (r_valid),
      .r_data    (r_data),
      .r_resp    (r_resp),
      .aw_ready  (aw_ready),
      .aw_valid  (aw_valid),
      .aw_addr   (aw_addr),
      .aw_size   (aw_size),
      .w_ready   (w_ready),
      .w_valid   (w_valid),
      .w_data    (w_data),
      .w_strb    (w_strb),
      .b_ready   (b_ready),
      .b_valid   (b_valid),
      .b_resp    (b_resp)
   );

   axi_unc_ram
   #(
      .axi_addr_width (axi_addr_width),
      .axi_p_dw_bytes (axi_p_dw_bytes),
      .ram_p_depth    (ram_p_depth)
   )
   u_ram
   (
      .clk      (clk),
      .reset    (reset),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .ar_addr  (ar_addr),
      .ar_size  (ar_size),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .r_data   (r_data),
      .r_resp   (r_resp),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .aw_addr  (aw_addr),
      .aw_size  (aw_size),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .w_data   (w_data),
      .w_strb   (w_strb),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .b_resp   (b_resp)
   );

endmodule

/* bench/lsu_unc_chk.sv */
//////////////////////////////
// Bound checks on the access FSM
// AXI valid hold, boot to valid latency,
// stall request from boot to valid
//////////////////////////////

`timescale 1ns/10ps

module lsu_unc_chk
(
   input logic clk,
   input logic reset,
   input logic boot,
   input logic valid,
   input logic stall_req,
   input logic ar_valid,
   input logic ar_ready,
   input logic r_valid,
   input logic r_ready,
   input logic aw_valid,
   input logic aw_ready,
   input logic w_valid,
   input logic w_ready,
   input logic b_valid,
   input logic b_ready
);

   // Failures seen so far, watched by the testbench
   int fail_cnt = 0;

   a_ar_hold : assert property (@(posedge clk) disable iff (reset)
      ar_valid && !ar_ready |=> ar_valid)
   else
   begin
      fail_cnt++;
      $error("ar_valid dropped before its handshake");
   end

   a_r_hold : assert property (@(posedge clk) disable iff (reset)
      r_valid && !r_ready |=> r_valid)
   else
   begin
      fail_cnt++;
      $error("r_valid dropped before its handshake");
   end

   a_aw_hold : assert property (@(posedge clk) disable iff (reset)
      aw_valid && !aw_ready |=> aw_valid)
   else
   begin
      fail_cnt++;
      $error("aw_valid dropped before its handshake");
   end

   a_w_hold : assert property (@(posedge clk) disable iff (reset)
      w_valid && !w_ready |=> w_valid)
   else
   begin
      fail_cnt++;
      $error("w_valid dropped before its handshake");
   end

   a_b_hold : assert property (@(posedge clk) disable iff (reset)
      b_valid && !b_ready |=> b_valid)
   else
   begin
      fail_cnt++;
      $error("b_valid dropped before its handshake");
   end

   // Result exactly three cycles after boot
   a_latency : assert property (@(posedge clk) disable iff (reset)
      boot |-> !valid ##1 !valid ##1 !valid ##1 valid)
   else
   begin
      fail_cnt++;
      $error("valid did not follow boot by three cycles");
   end

   // Stall request held from boot, released as valid rises
   a_req_span : assert property (@(posedge clk) disable iff (reset)
      boot |-> stall_req [*3] ##1 (valid && !stall_req))
   else
   begin
      fail_cnt++;
      $error("stall_req not held from boot until valid");
   end

endmodule

/* bench/tb_lsu_unc.sv */
//////////////////////////////
// Testbench for the uncached load/store path
// Clock, reset, random accesses, reference memory,
// result comparison and watchdog
//////////////////////////////

`timescale 1ns/10ps

module tb_lsu_unc;
   import lsu_pkg::*;

   // At most 4 cycles per access plus 3 stall cycles
   localparam int max_access = 280;
   localparam int max_cycles = max_access * 7 + 40;

   logic         clk;
   logic         reset;
   logic         stall;
   logic         boot;
   logic         store;
   logic [31:0]  paddr;
   logic [2:0]   size;
   logic [31:0]  wdat;
   logic [3:0]   wmsk;
   logic         stall_req;
   logic         valid;
   logic [31:0]  dout;
   logic         err;

   // 4 KB of RAM as 32-bit words
   logic [31:0]  ref_mem [1024];
   logic [32:0]  exp_q [$];
   logic [31:0]  rng_state = 32'h278c_37f0;
   int           n_issued = 0;
   int           n_done = 0;
   int           cycles = 0;

   lsu_unc_top u_lsu_unc_top
   (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .boot      (boot),
      .store     (store),
      .paddr     (paddr),
      .size      (size),
      .wdat      (wdat),
      .wmsk      (wmsk),
      .stall_req (stall_req),
      .valid     (valid),
      .dout      (dout),
      .err       (err)
   );

   bind lsu_unc_fsm lsu_unc_chk u_chk (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Truncated address below 4 KB, random upper bits
   function automatic logic [31:0] addr_in_range();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[31:16], 4'h0, lo[29:20], 2'b00};
   endfunction

   function automatic logic [31:0] addr_out_range();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [3:0]  nib;
      hi = next_rand();
      lo = next_rand();
      nib = (lo[19:16] == 4'h0) ? 4'h8 : lo[19:16];
      return {hi[31:16], nib, lo[29:20], 2'b00};
   endfunction

   // Expected {err, dout}, stores update the model
   function automatic logic [32:0] ref_access(input logic st, input logic [31:0] addr,
                                               input logic [31:0] data, input logic [3:0] msk);
      logic [15:0] taddr;
      logic [31:0] word;
      taddr = addr[15:0];
      if (taddr >= 16'h1000)
         return {1'b1, 32'h0};
      word = ref_mem[taddr[11:2]];
      if (!st)
         return {1'b0, word};
      for (int b = 0; b < 4; b++)
         if (msk[b])
            word[b*8 +: 8] = data[b*8 +: 8];
      ref_mem[taddr[11:2]] = word;
      return {1'b0, 32'h0};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // One access from boot until the FSM is idle again
   task automatic run_access(input logic st, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] msk);
      logic [31:0] r;
      int          hold;
      r = next_rand();
      hold = int'(r[17:16]);
      exp_q.push_back(ref_access(st, addr, data, msk));
      n_issued++;
      boot = 1'b1;
      store = st;
      paddr = addr;
      wdat = data;
      wmsk = msk;
      size = AXI_SIZE_WORD;
      stall = (hold != 0);
      #2;
      check_val("stall_req", {31'd0, stall_req}, 32'd1);
      @(posedge clk);
      #1;
      boot = 1'b0;
      while (!valid)
      begin
         @(posedge clk);
         #1;
      end
      repeat (hold)
      begin
         @(posedge clk);
         #1;
      end
      stall = 1'b0;
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] r;
      reset = 1'b1;
      stall = 1'b0;
      boot = 1'b0;
      store = 1'b0;
      paddr = '0;
      size = AXI_SIZE_WORD;
      wdat = '0;
      wmsk = '0;
      for (int i = 0; i < 1024; i++)
         ref_mem[i] = 32'h0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      // Quiet outputs before the first boot
      repeat (3)
      begin
         @(posedge clk);
         #1;
         check_val("stall_req", {31'd0, stall_req}, 32'd0);
         check_val("valid", {31'd0, valid}, 32'd0);
      end
      // Freshly reset RAM reads zero
      for (int i = 0; i < 8; i++)
         run_access(1'b0, addr_in_range(), 32'h0, 4'h0);
      // Both windows of one 64-bit line
      for (int i = 0; i < 16; i++)
      begin
         a = addr_in_range() & ~32'h4;
         d = next_rand();
         run_access(1'b1, a, d, 4'hf);
         run_access(1'b1, a | 32'h4, ~d, 4'hf);
         run_access(1'b0, a, 32'h0, 4'h0);
         run_access(1'b0, a | 32'h4, 32'h0, 4'h0);
      end
      // Partial byte masks over a known old word
      for (int i = 0; i < 26; i++)
      begin
         a = addr_in_range();
         d = next_rand();
         r = next_rand();
         run_access(1'b1, a, ~d, 4'hf);
         run_access(1'b1, a, d, r[23:20]);
         run_access(1'b0, a, 32'h0, 4'h0);
      end
      // Upper address bits alias
      for (int i = 0; i < 20; i++)
      begin
         a = addr_in_range();
         d = next_rand();
         r = next_rand();
         run_access(1'b1, a, d, 4'hf);
         run_access(1'b0, {a[31:16] ^ (r[31:16] | 16'h1), a[15:0]}, 32'h0, 4'h0);
      end
      // Beyond 4 KB, then the word a bad decode would hit
      for (int i = 0; i < 15; i++)
      begin
         a = addr_out_range();
         d = next_rand();
         run_access(1'b1, a, d, 4'hf);
         run_access(1'b0, a, 32'h0, 4'h0);
         run_access(1'b0, {a[31:16], 4'h0, a[11:0]}, 32'h0, 4'h0);
      end
      for (int i = 0; i < 40; i++)
      begin
         r = next_rand();
         a = (r[27:25] == 3'd0) ? addr_out_range() : addr_in_range();
         run_access(r[24], a, next_rand(), r[23:20]);
      end
      if (n_done == n_issued && u_lsu_unc_top.u_fsm.u_chk.fail_cnt == 0)
      begin
         $display("Result: PASSED");
         $finish;
      end
      else
      begin
         $display("Counted %0d results for %0d accesses", n_done, n_issued);
         $display("Result: FAILED");
         $fatal(1, "result count mismatch");
      end
   end

   // Checks every valid cycle, one result per access
   always @(posedge clk)
   begin : compare_results
      logic [32:0] head;
      if (!reset && valid)
      begin
         if (exp_q.size() == 0)
         begin
            $display("valid was high with no access outstanding");
            $display("Result: FAILED");
            $fatal(1, "unexpected result");
         end
         else
         begin
            head = exp_q[0];
            check_val("dout", dout, head[31:0]);
            check_val("err", {31'd0, err}, {31'd0, head[32]});
            if (!stall)
            begin
               head = exp_q.pop_front();
               n_done++;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (u_lsu_unc_top.u_fsm.u_chk.fail_cnt != 0)
      begin
         $display("A protocol assertion on the access FSM failed");
         $display("Result: FAILED");
         $fatal(1, "assertion failure");
      end
      else if (cycles >= max_cycles)
      begin
         $display("Timeout after %0d cycles, valid never came", cycles);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

endmodule

/* lsu_unc.f */
verilog/lsu_pkg.sv
verilog/lsu_unc_fsm.sv
verilog/axi_unc_ram.sv
verilog/lsu_unc_top.sv
bench/lsu_unc_chk.sv
bench/tb_lsu_unc.sv

/* Makefile */
TOP = tb_lsu_unc

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f lsu_unc.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
